// ==== logic/cast_pkg.sv ====
// Shared widths, encodings and the operand view for the float/int conversion unit
package cast_pkg;

  // --------------------
  // Formats
  // --------------------
  localparam int DATA_WIDTH    = 32;  // Operand and result word
  localparam int EXP_BITS      = 8;   // binary32 exponent
  localparam int MAN_BITS      = 23;  // binary32 stored mantissa
  localparam int BIAS          = 127;

  // Internal mantissa holds the hidden bit or a whole integer
  localparam int INT_MAN_WIDTH = (MAN_BITS + 1 > DATA_WIDTH) ? MAN_BITS + 1 : DATA_WIDTH;
  localparam int INT_EXP_WIDTH = 10;  // Signed, covers smallest denormal
  localparam int LZC_WIDTH     = 5;   // Leading-zero count

  // --------------------
  // Status flags
  // --------------------
  localparam int STATUS_WIDTH = 5;
  localparam int STATUS_NV    = 4;  // Invalid
  localparam int STATUS_DZ    = 3;  // Divide by zero, unused here
  localparam int STATUS_OF    = 2;  // Overflow
  localparam int STATUS_UF    = 1;  // Underflow
  localparam int STATUS_NX    = 0;  // Inexact

  // --------------------
  // Encodings
  // --------------------
  localparam logic [2:0] RND_RNE = 3'd0;  // Nearest, ties to even
  localparam logic [2:0] RND_RTZ = 3'd1;  // Toward zero
  localparam logic [2:0] RND_RDN = 3'd2;  // Toward minus infinity
  localparam logic [2:0] RND_RUP = 3'd3;  // Toward plus infinity
  localparam logic [2:0] RND_RMM = 3'd4;  // Nearest, ties away

  localparam logic OP_F2I = 1'b0;
  localparam logic OP_I2F = 1'b1;

  // Canonical quiet NaN
  localparam logic [DATA_WIDTH-1:0] QNAN_BITS = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  // One operand word, read as a float or as a raw integer
  typedef union packed {
    struct packed {
      logic                sign;
      logic [EXP_BITS-1:0] exp;
      logic [MAN_BITS-1:0] man;
    } fp;
    logic [DATA_WIDTH-1:0] raw;
  } operand_u;

endpackage

// ==== logic/cast_pipe_reg.sv ====
// Single valid/ready register stage with flush, used twice in the conversion pipeline
`timescale 1ns/1ps

module cast_pipe_reg #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,   // Drop the held item
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] data_q;

  // Accept when downstream takes ours or when we hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Pop and push in the same edge
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;  // Payload loads on accept only
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Stalled item must not change under back-pressure
  stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> $stable(data_o));

endmodule

// ==== logic/cast_normalize.sv ====
// Input stage of the converter: classifies a float or takes an integer magnitude, then normalizes
`timescale 1ns/1ps

module cast_normalize (
  input  logic [cast_pkg::DATA_WIDTH-1:0]           operand_i,
  input  logic                                      op_i,       // F2I or I2F
  input  logic                                      op_mod_i,   // Unsigned integer
  output logic                                      sign_o,
  output logic signed [cast_pkg::INT_EXP_WIDTH-1:0] exp_o,      // Unbiased
  output logic [cast_pkg::INT_MAN_WIDTH-1:0]        mant_o,     // Leading one at the top
  output logic                                      mant_zero_o,
  output logic                                      is_nan_o,
  output logic                                      is_snan_o,
  output logic                                      is_inf_o,
  output logic                                      is_zero_o
);

  localparam int MW = cast_pkg::INT_MAN_WIDTH;
  localparam int EW = cast_pkg::INT_EXP_WIDTH;

  cast_pkg::operand_u opnd;

  logic src_is_int;
  logic exp_zero, exp_ones, man_zero;
  logic is_normal, is_subnormal;
  logic int_sign;

  logic [MW-1:0]                  int_mag, enc_mant;
  logic [cast_pkg::LZC_WIDTH-1:0] lzc;
  logic signed [EW-1:0]           shamt_s, fp_exp, int_exp;

  assign opnd       = operand_i;
  assign src_is_int = (op_i == cast_pkg::OP_I2F);

  // --------------------
  // Float classification
  // --------------------
  assign exp_zero     = (opnd.fp.exp == '0);
  assign exp_ones     = (opnd.fp.exp == '1);
  assign man_zero     = (opnd.fp.man == '0);
  assign is_normal    = ~exp_zero & ~exp_ones;
  assign is_subnormal = exp_zero & ~man_zero;

  // Class bits describe float sources only
  assign is_nan_o  = ~src_is_int & exp_ones & ~man_zero;
  assign is_snan_o = is_nan_o & ~opnd.fp.man[cast_pkg::MAN_BITS-1];  // Quiet bit clear
  assign is_inf_o  = ~src_is_int & exp_ones & man_zero;
  assign is_zero_o = ~src_is_int & exp_zero & man_zero;

  // --------------------
  // Integer magnitude
  // --------------------
  assign int_sign = opnd.raw[cast_pkg::DATA_WIDTH-1] & ~op_mod_i;  // Unsigned never negative
  assign int_mag  = int_sign ? MW'(-opnd.raw) : MW'(opnd.raw);

  // Float mantissa sits at the bottom, hidden bit included
  assign enc_mant = src_is_int ? int_mag : MW'({is_normal, opnd.fp.man});

  // Leading-zero count, highest set bit wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < MW; i++) begin
      if (enc_mant[i]) lzc = cast_pkg::LZC_WIDTH'(MW - 1 - i);
    end
  end

  assign mant_zero_o = ~|enc_mant;  // Integer zero
  assign mant_o      = enc_mant << lzc;
  assign shamt_s     = EW'({1'b0, lzc});

  // Unbias, undo the shift and the width offset of the float mantissa
  assign fp_exp  = EW'($signed({1'b0, opnd.fp.exp}) + $signed({1'b0, is_subnormal})
                       - cast_pkg::BIAS - shamt_s + (MW - 1 - cast_pkg::MAN_BITS));
  assign int_exp = EW'(MW - 1) - shamt_s;  // Bit position of the leading one

  assign exp_o  = src_is_int ? int_exp : fp_exp;
  assign sign_o = src_is_int ? int_sign : opnd.fp.sign;

endmodule

// ==== logic/cast_denorm.sv ====
// Middle stage of the converter: shifts the mantissa into float or integer place, finds R/S bits
`timescale 1ns/1ps

module cast_denorm (
  input  logic                                      op_i,
  input  logic                                      op_mod_i,
  input  logic signed [cast_pkg::INT_EXP_WIDTH-1:0] exp_i,
  input  logic [cast_pkg::INT_MAN_WIDTH-1:0]        mant_i,
  input  logic                                      is_inf_i,
  output logic [cast_pkg::EXP_BITS-1:0]             final_exp_o,
  output logic [cast_pkg::MAN_BITS-1:0]             final_mant_o,
  output logic [cast_pkg::DATA_WIDTH-1:0]           final_int_o,
  output logic [1:0]                                fp_rs_o,      // Round, sticky
  output logic [1:0]                                int_rs_o,
  output logic                                      of_before_o,
  output logic                                      uf_before_o
);

  localparam int MW         = cast_pkg::INT_MAN_WIDTH;
  localparam int EW         = cast_pkg::INT_EXP_WIDTH;
  localparam int SHW        = $clog2(MW + 1);
  localparam int MAX_EXP    = 2**cast_pkg::EXP_BITS - 1;
  localparam int FP_STICKY  = 2 * MW - cast_pkg::MAN_BITS - 1;  // Below mantissa and R
  localparam int INT_STICKY = 2 * MW - cast_pkg::DATA_WIDTH;    // Below integer and R

  logic signed [EW-1:0] dst_exp;   // Rebiased
  logic signed [EW-1:0] ovf_exp;   // First exponent out of integer range
  logic [2*MW:0]        preshift_mant, dest_mant;
  logic [SHW-1:0]       shamt;

  assign dst_exp = exp_i + EW'(cast_pkg::BIAS);
  assign ovf_exp = op_mod_i ? EW'(cast_pkg::DATA_WIDTH) : EW'(cast_pkg::DATA_WIDTH - 1);

  always_comb begin
    final_exp_o   = dst_exp[cast_pkg::EXP_BITS-1:0];  // Low bits only
    preshift_mant = {mant_i, {(MW+1){1'b0}}};         // Mantissa to the left of the shifter
    shamt         = '0;
    of_before_o   = 1'b0;
    uf_before_o   = 1'b0;

    if (op_i == cast_pkg::OP_F2I) begin
      shamt = SHW'(cast_pkg::DATA_WIDTH - 1 - exp_i);  // Right shift to integer place
      if (is_inf_i || exp_i >= ovf_exp) begin
        shamt       = '0;
        of_before_o = 1'b1;
      end else if (exp_i < -1) begin
        shamt       = SHW'(cast_pkg::DATA_WIDTH + 1);  // Everything into sticky
        uf_before_o = 1'b1;
      end
    end else begin
      // Saturate to largest normal, RS set for correct rounding
      if (dst_exp >= MAX_EXP) begin
        final_exp_o   = cast_pkg::EXP_BITS'(MAX_EXP - 1);
        preshift_mant = '1;
        of_before_o   = 1'b1;
      end else if (dst_exp < 1 && dst_exp >= -cast_pkg::MAN_BITS) begin
        final_exp_o = '0;                    // Denormal
        shamt       = SHW'(1 - dst_exp);
        uf_before_o = 1'b1;
      end else if (dst_exp < -cast_pkg::MAN_BITS) begin
        final_exp_o = '0;
        shamt       = SHW'(2 + cast_pkg::MAN_BITS);  // Limit shift, keep sticky
        uf_before_o = 1'b1;
      end
    end
  end

  assign dest_mant = preshift_mant >> shamt;

  // Hidden bit dropped for floats
  assign {final_mant_o, fp_rs_o[1]} = dest_mant[2*MW-1 -: cast_pkg::MAN_BITS+1];
  assign {final_int_o, int_rs_o[1]} = dest_mant[2*MW -: cast_pkg::DATA_WIDTH+1];
  assign fp_rs_o[0]  = |dest_mant[FP_STICKY-1:0];
  assign int_rs_o[0] = |dest_mant[INT_STICKY-1:0];

endmodule

// ==== logic/cast_round_result.sv ====
// Output stage of the converter: rounds, resolves special cases and forms result and flags
`timescale 1ns/1ps

module cast_round_result (
  input  logic                                op_i,
  input  logic                                op_mod_i,
  input  logic [2:0]                          rnd_mode_i,
  input  logic                                sign_i,
  input  logic                                mant_zero_i,
  input  logic                                is_nan_i,
  input  logic                                is_snan_i,
  input  logic                                is_inf_i,
  input  logic                                is_zero_i,
  input  logic [cast_pkg::EXP_BITS-1:0]       final_exp_i,
  input  logic [cast_pkg::MAN_BITS-1:0]       final_mant_i,
  input  logic [cast_pkg::DATA_WIDTH-1:0]     final_int_i,
  input  logic [1:0]                          fp_rs_i,
  input  logic [1:0]                          int_rs_i,
  input  logic                                of_before_i,
  input  logic                                uf_before_i,
  output logic [cast_pkg::DATA_WIDTH-1:0]     result_o,
  output logic [cast_pkg::STATUS_WIDTH-1:0]   status_o
);

  localparam int DW = cast_pkg::DATA_WIDTH;
  localparam int MB = cast_pkg::MAN_BITS;
  localparam int EB = cast_pkg::EXP_BITS;

  logic          dst_is_int, src_is_int;
  logic [DW-1:0] pre_round_abs, rounded_abs, rounded_int;
  logic [1:0]    rs;
  logic          round_up, rounded_int_zero;
  logic          of_after, uf_after;

  cast_pkg::operand_u fp_res;

  logic [DW-1:0]                       fp_special_res, int_special_res;
  logic                                fp_special, int_special;
  logic [cast_pkg::STATUS_WIDTH-1:0]   fp_status, int_status;

  assign dst_is_int = (op_i == cast_pkg::OP_F2I);
  assign src_is_int = ~dst_is_int;

  // --------------------
  // Rounding
  // --------------------
  assign pre_round_abs = dst_is_int ? final_int_i : DW'({final_exp_i, final_mant_i});
  assign rs            = dst_is_int ? int_rs_i : fp_rs_i;

  always_comb begin
    case (rnd_mode_i)
      cast_pkg::RND_RNE: round_up = rs[1] & (rs[0] | pre_round_abs[0]);  // Tie to even
      cast_pkg::RND_RTZ: round_up = 1'b0;
      cast_pkg::RND_RDN: round_up = (|rs) & sign_i;
      cast_pkg::RND_RUP: round_up = (|rs) & ~sign_i;
      cast_pkg::RND_RMM: round_up = rs[1];                               // Tie away
      default:           round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + DW'(round_up);

  // Exponent field after rounding
  assign uf_after = (rounded_abs[MB +: EB] == '0);
  assign of_after = (rounded_abs[MB +: EB] == '1);

  // Float result, integer zero gives +0
  always_comb begin
    fp_res.fp.sign = sign_i;
    fp_res.fp.exp  = rounded_abs[MB +: EB];
    fp_res.fp.man  = rounded_abs[MB-1:0];
    if (src_is_int && mant_zero_i) fp_res.raw = '0;
  end

  assign rounded_int      = sign_i ? DW'(-rounded_abs) : rounded_abs;  // Two's complement
  assign rounded_int_zero = (rounded_int == '0);

  // --------------------
  // Special cases
  // --------------------
  assign fp_special     = is_zero_i | is_nan_i;  // Only float sources carry class bits
  assign fp_special_res = is_nan_i ? cast_pkg::QNAN_BITS : {sign_i, {(DW-1){1'b0}}};

  // Saturation: signed or unsigned max, flipped for negatives except NaN
  always_comb begin
    int_special_res = {op_mod_i, {(DW-1){1'b1}}};
    if (sign_i && !is_nan_i) int_special_res = ~int_special_res;
  end

  assign int_special = is_nan_i | is_inf_i | of_before_i |
                       (sign_i & op_mod_i & ~rounded_int_zero);  // Negative to unsigned

  // --------------------
  // Status
  // --------------------
  always_comb begin
    fp_status                     = '0;
    fp_status[cast_pkg::STATUS_NX] = (|fp_rs_i) |
                                     (~src_is_int & ~is_inf_i & (of_before_i | of_after));
    fp_status[cast_pkg::STATUS_NV] = src_is_int & (of_before_i | of_after);  // No int overflow
    fp_status[cast_pkg::STATUS_OF] = ~src_is_int & ~is_inf_i & (of_before_i | of_after);
    fp_status[cast_pkg::STATUS_UF] = (uf_before_i | uf_after) & fp_status[cast_pkg::STATUS_NX];
    if (fp_special) begin
      fp_status                     = '0;
      fp_status[cast_pkg::STATUS_NV] = is_snan_i;  // Signalling NaN only
    end

    int_status                     = '0;
    int_status[cast_pkg::STATUS_NX] = |int_rs_i;
    if (int_special) begin
      int_status                     = '0;
      int_status[cast_pkg::STATUS_NV] = 1'b1;  // Every saturation is invalid
    end
  end

  assign result_o = dst_is_int ? (int_special ? int_special_res : rounded_int)
                               : (fp_special  ? fp_special_res  : fp_res.raw);
  assign status_o = dst_is_int ? int_status : fp_status;

  dz_never_set: assert final (!status_o[cast_pkg::STATUS_DZ]);

endmodule

// ==== logic/fp_int_cast.sv ====
// Top of the binary32/int32 converter: normalize, register, denormalize and round, register
`timescale 1ns/1ps

module fp_int_cast (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [cast_pkg::DATA_WIDTH-1:0]     operand_i,
  input  logic                                op_i,
  input  logic                                op_mod_i,
  input  logic [2:0]                          rnd_mode_i,
  input  logic                                in_valid_i,
  output logic                                in_ready_o,
  input  logic                                flush_i,
  output logic [cast_pkg::DATA_WIDTH-1:0]     result_o,
  output logic [cast_pkg::STATUS_WIDTH-1:0]   status_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic                                busy_o
);

  localparam int MW    = cast_pkg::INT_MAN_WIDTH;
  localparam int EW    = cast_pkg::INT_EXP_WIDTH;
  localparam int MID_W = 1 + EW + MW + 1 + 4 + 1 + 1 + 3;  // Number, class, op, mode
  localparam int OUT_W = cast_pkg::DATA_WIDTH + cast_pkg::STATUS_WIDTH;

  // --------------------
  // Normalize
  // --------------------
  logic                 n_sign, n_mant_zero, n_nan, n_snan, n_inf, n_zero;
  logic signed [EW-1:0] n_exp;
  logic [MW-1:0]        n_mant;

  cast_normalize u_normalize (
    .operand_i   (operand_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .sign_o      (n_sign),
    .exp_o       (n_exp),
    .mant_o      (n_mant),
    .mant_zero_o (n_mant_zero),
    .is_nan_o    (n_nan),
    .is_snan_o   (n_snan),
    .is_inf_o    (n_inf),
    .is_zero_o   (n_zero)
  );

  // --------------------
  // Mid register
  // --------------------
  logic [MID_W-1:0] mid_d, mid_q;
  logic             mid_valid, mid_ready;

  logic                 m_sign, m_mant_zero, m_nan, m_snan, m_inf, m_zero, m_op, m_op_mod;
  logic signed [EW-1:0] m_exp;
  logic [MW-1:0]        m_mant;
  logic [2:0]           m_rnd;

  assign mid_d = {n_sign, n_exp, n_mant, n_mant_zero, n_nan, n_snan, n_inf, n_zero,
                  op_i, op_mod_i, rnd_mode_i};

  cast_pipe_reg #(.DataWidth(MID_W)) u_mid_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (mid_d),
    .valid_o (mid_valid),
    .ready_i (mid_ready),   // Backwards from the out stage
    .data_o  (mid_q)
  );

  assign {m_sign, m_exp, m_mant, m_mant_zero, m_nan, m_snan, m_inf, m_zero,
          m_op, m_op_mod, m_rnd} = mid_q;

  // --------------------
  // Denormalize, round
  // --------------------
  logic [cast_pkg::EXP_BITS-1:0]     d_exp;
  logic [cast_pkg::MAN_BITS-1:0]     d_mant;
  logic [cast_pkg::DATA_WIDTH-1:0]   d_int, r_result;
  logic [1:0]                        d_fp_rs, d_int_rs;
  logic                              d_of, d_uf;
  logic [cast_pkg::STATUS_WIDTH-1:0] r_status;

  cast_denorm u_denorm (
    .op_i         (m_op),
    .op_mod_i     (m_op_mod),
    .exp_i        (m_exp),
    .mant_i       (m_mant),
    .is_inf_i     (m_inf),
    .final_exp_o  (d_exp),
    .final_mant_o (d_mant),
    .final_int_o  (d_int),
    .fp_rs_o      (d_fp_rs),
    .int_rs_o     (d_int_rs),
    .of_before_o  (d_of),
    .uf_before_o  (d_uf)
  );

  cast_round_result u_round_result (
    .op_i         (m_op),
    .op_mod_i     (m_op_mod),
    .rnd_mode_i   (m_rnd),
    .sign_i       (m_sign),
    .mant_zero_i  (m_mant_zero),
    .is_nan_i     (m_nan),
    .is_snan_i    (m_snan),
    .is_inf_i     (m_inf),
    .is_zero_i    (m_zero),
    .final_exp_i  (d_exp),
    .final_mant_i (d_mant),
    .final_int_i  (d_int),
    .fp_rs_i      (d_fp_rs),
    .int_rs_i     (d_int_rs),
    .of_before_i  (d_of),
    .uf_before_i  (d_uf),
    .result_o     (r_result),
    .status_o     (r_status)
  );

  // --------------------
  // Out register
  // --------------------
  cast_pipe_reg #(.DataWidth(OUT_W)) u_out_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (mid_valid),
    .ready_o (mid_ready),
    .data_i  ({r_result, r_status}),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  ({result_o, status_o})
  );

  assign busy_o = mid_valid | out_valid_o;  // Any stage occupied

  // Flush reaches both stages in one edge
  flush_empties: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |=> !out_valid_o);

endmodule

// ==== dv/tb_fp_int_cast.sv ====
// Self-checking testbench for the float/int converter, run as the simulation top with the RTL
`timescale 1ns/1ps

module tb_fp_int_cast;

  localparam int CLK_PERIOD  = 100;
  localparam int N_SIGNED    = 6;    // Random signed items per mode
  localparam int N_UNSIGNED  = 2;    // Random unsigned items per mode
  localparam int N_STALL     = 40;
  localparam int DRAIN_LIMIT = 20;
  localparam int TOTAL_ITEMS = 5 * (N_SIGNED + N_UNSIGNED) + 23 + 6 + 2 + N_STALL + 2;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 20 + 200;  // Plus margin for drains

  localparam logic [4:0] ST_NONE = 5'b00000;
  localparam logic [4:0] ST_NX   = 5'b00001 << cast_pkg::STATUS_NX;
  localparam logic [4:0] ST_NV   = 5'b00001 << cast_pkg::STATUS_NV;

  // DUT inputs start known
  logic        clk_i       = 1'b0;
  logic        rst_i       = 1'b1;
  logic [31:0] operand_i   = '0;
  logic        op_i        = 1'b0;
  logic        op_mod_i    = 1'b0;
  logic [2:0]  rnd_mode_i  = '0;
  logic        in_valid_i  = 1'b0;
  logic        flush_i     = 1'b0;
  logic        out_ready_i = 1'b1;

  logic        in_ready_o, out_valid_o, busy_o;
  logic [31:0] result_o;
  logic [4:0]  status_o;

  // Expected values travel next to the inputs
  logic [31:0] exp_res_drv  = '0;
  logic [4:0]  exp_stat_drv = '0;
  logic [36:0] exp_q[$];                // {result, status} per accepted item
  logic [31:0] head_res   = '0;
  logic [4:0]  head_stat  = '0;
  logic        head_empty = 1'b1;

  int seed = 59645;
  int fail_cnt, test_items, test_cnt, total_items, fails_at_start;
  logic stall_en = 1'b0;                // Random back-pressure on

  fp_int_cast u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .operand_i   (operand_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Scoreboard queue
  // --------------------
  always @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      exp_q.delete();                   // Flushed items never come out
    end else begin
      if (out_valid_o && out_ready_i && exp_q.size() != 0) void'(exp_q.pop_front());
      if (in_valid_i && in_ready_o) exp_q.push_back({exp_res_drv, exp_stat_drv});
    end
    head_empty <= (exp_q.size() == 0);
    if (exp_q.size() != 0) begin
      head_res  <= exp_q[0][36:5];
      head_stat <= exp_q[0][4:0];
    end
  end

  // --------------------
  // Checks
  // --------------------
  result_match: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i |-> result_o == head_res)
    else begin
      fail_cnt++;
      $display("Fail %0t: result %h, expected %h", $time, $sampled(result_o), $sampled(head_res));
    end

  status_match: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i |-> status_o == head_stat)
    else begin
      fail_cnt++;
      $display("Fail %0t: status %b, expected %b", $time, $sampled(status_o), $sampled(head_stat));
    end

  no_extra_output: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i |-> !head_empty)
    else begin
      fail_cnt++;
      $display("An output appeared at %0t with no item outstanding", $time);
    end

  stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o) &&
    $stable(status_o))
    else begin
      fail_cnt++;
      $display("The stalled output changed or vanished at %0t", $time);
    end

  ready_rule: assert property (@(posedge clk_i) disable iff (rst_i)
    !in_ready_o |-> out_valid_o && !out_ready_i)  // Input blocks only when both stages full
    else begin
      fail_cnt++;
      $display("Input ready was low at %0t while the pipeline could move", $time);
    end

  idle_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !out_valid_o && !busy_o && in_ready_o)
    else begin
      fail_cnt++;
      $display("The pipeline was not idle after reset at %0t", $time);
    end

  flush_clears: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |=> !busy_o)
    else begin
      fail_cnt++;
      $display("Busy stayed high after a flush at %0t", $time);
    end

  // Exact binary32 bits of a real value including zero
  function automatic logic [31:0] single_bits(input real value);
    logic [63:0] d;
    logic [10:0] e;
    d = $realtobits(value);
    e = d[62:52];
    if (e == '0) return {d[63], 31'b0};
    return {d[63], 8'(e - 11'd896), d[51:29]};  // Rebias 1023 to 127
  endfunction

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic send_item(input logic [31:0] opnd, input logic op, input logic md,
                           input logic [2:0] rnd, input logic [31:0] res,
                           input logic [4:0] stat);
    operand_i    <= opnd;
    op_i         <= op;
    op_mod_i     <= md;
    rnd_mode_i   <= rnd;
    exp_res_drv  <= res;
    exp_stat_drv <= stat;
    in_valid_i   <= 1'b1;
    if (stall_en) out_ready_i <= 1'($random(seed));
    @(posedge clk_i);
    while (!in_ready_o) begin           // Held until accepted
      if (stall_en) out_ready_i <= 1'($random(seed));
      @(posedge clk_i);
    end
    test_items++;
  endtask

  task automatic drain_pipe();
    int cycles;
    cycles      = 0;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
    @(posedge clk_i);
    while (busy_o && cycles < DRAIN_LIMIT) begin
      cycles++;
      @(posedge clk_i);
    end
    if (busy_o) begin
      fail_cnt++;
      $display("The pipeline stayed busy for %0d cycles while draining", DRAIN_LIMIT);
    end
    @(posedge clk_i);
  endtask

  task automatic finish_test(input string name);
    drain_pipe();
    $display("%s: items %0d errors %0d", name, test_items, fail_cnt - fails_at_start);
    test_cnt++;
    total_items    += test_items;
    test_items     = 0;
    fails_at_start = fail_cnt;
  endtask

  // F2I of four inexact halves in one mode
  task automatic run_ties(input logic [2:0] mode, input int p15, input int m15,
                          input int p25, input int m25);
    send_item(single_bits(1.5), cast_pkg::OP_F2I, 1'b0, mode, p15, ST_NX);
    send_item(single_bits(-1.5), cast_pkg::OP_F2I, 1'b0, mode, m15, ST_NX);
    send_item(single_bits(2.5), cast_pkg::OP_F2I, 1'b0, mode, p25, ST_NX);
    send_item(single_bits(-2.5), cast_pkg::OP_F2I, 1'b0, mode, m25, ST_NX);
  endtask

  // One exactly representable I2F item of either signedness
  task automatic send_exact_i2f(input logic [2:0] mode, input logic unsgn);
    int v;
    logic [31:0] u;
    if (unsgn) begin
      u = $random(seed) & 32'h00FF_FFFF;  // Below 2^24
      send_item(u, cast_pkg::OP_I2F, 1'b1, mode, single_bits(real'(u)), ST_NONE);
    end else begin
      v = $random(seed) % 32'sd16777216;  // Magnitude below 2^24
      send_item(v, cast_pkg::OP_I2F, 1'b0, mode, single_bits(real'(v)), ST_NONE);
    end
  endtask

  // --------------------
  // Sequence
  // --------------------
  initial begin
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    for (int m = 0; m < 5; m++) begin
      for (int i = 0; i < N_SIGNED; i++) send_exact_i2f(3'(m), 1'b0);
      for (int i = 0; i < N_UNSIGNED; i++) send_exact_i2f(3'(m), 1'b1);
    end
    finish_test("exact_i2f");

    send_item(32'd16777217, cast_pkg::OP_I2F, 1'b0, cast_pkg::RND_RNE,
              single_bits(16777216.0), ST_NX);
    send_item(32'd16777217, cast_pkg::OP_I2F, 1'b0, cast_pkg::RND_RDN,
              single_bits(16777216.0), ST_NX);
    send_item(32'd16777217, cast_pkg::OP_I2F, 1'b0, cast_pkg::RND_RUP,
              single_bits(16777218.0), ST_NX);
    run_ties(cast_pkg::RND_RNE, 2, -2, 2, -2);
    run_ties(cast_pkg::RND_RTZ, 1, -1, 2, -2);
    run_ties(cast_pkg::RND_RDN, 1, -2, 2, -3);
    run_ties(cast_pkg::RND_RUP, 2, -1, 3, -2);
    run_ties(cast_pkg::RND_RMM, 2, -2, 3, -3);
    finish_test("rounding");

    send_item(32'h7FC0_0000, cast_pkg::OP_F2I, 1'b0, cast_pkg::RND_RNE, 32'h7FFF_FFFF, ST_NV);
    send_item(32'h7F80_0000, cast_pkg::OP_F2I, 1'b0, cast_pkg::RND_RNE, 32'h7FFF_FFFF, ST_NV);
    send_item(single_bits(3.0e9), cast_pkg::OP_F2I, 1'b0, cast_pkg::RND_RNE,
              32'h7FFF_FFFF, ST_NV);
    send_item(32'hFF80_0000, cast_pkg::OP_F2I, 1'b0, cast_pkg::RND_RNE, 32'h8000_0000, ST_NV);
    send_item(single_bits(-3.0), cast_pkg::OP_F2I, 1'b1, cast_pkg::RND_RNE, 32'h0, ST_NV);
    send_item(single_bits(3.0e9), cast_pkg::OP_F2I, 1'b1, cast_pkg::RND_RNE,
              32'd3000000000, ST_NONE);
    finish_test("specials");

    send_item(32'h0, cast_pkg::OP_I2F, 1'b0, cast_pkg::RND_RNE, 32'h0, ST_NONE);
    send_item(32'h8000_0000, cast_pkg::OP_F2I, 1'b0, cast_pkg::RND_RNE, 32'h0, ST_NONE);
    finish_test("zeros");

    stall_en = 1'b1;                    // Random out_ready from here
    for (int i = 0; i < N_STALL; i++) begin
      send_exact_i2f(3'($unsigned($random(seed)) % 5), 1'b0);
    end
    stall_en = 1'b0;
    finish_test("backpressure");

    out_ready_i <= 1'b0;                // Fill both stages, then drop them
    send_item(32'd7, cast_pkg::OP_I2F, 1'b0, cast_pkg::RND_RNE, single_bits(7.0), ST_NONE);
    send_item(32'd9, cast_pkg::OP_I2F, 1'b0, cast_pkg::RND_RNE, single_bits(9.0), ST_NONE);
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(posedge clk_i);
    finish_test("flush");

    if (exp_q.size() != 0) begin
      fail_cnt++;
      $display("%0d expected results never came out of the pipeline", exp_q.size());
    end
    $display("Summary: %0d tests, %0d items, %0d errors", test_cnt, total_items, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the item count
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/cast_pkg.sv
logic/cast_pipe_reg.sv
logic/cast_normalize.sv
logic/cast_denorm.sv
logic/cast_round_result.sv
logic/fp_int_cast.sv
dv/tb_fp_int_cast.sv

// ==== Bender.yml ====
package:
  name: fp_int_cast

sources:
  - logic/cast_pkg.sv
  - logic/cast_pipe_reg.sv
  - logic/cast_normalize.sv
  - logic/cast_denorm.sv
  - logic/cast_round_result.sv
  - logic/fp_int_cast.sv
  - target: test
    files:
      - dv/tb_fp_int_cast.sv
